//--- verilog/stereo_cap_params.svh
/*
 * Frame geometry, raster timing and status counter widths
 * for the single-camera capture path
 */
`ifndef STEREO_CAP_PARAMS_SVH
`define STEREO_CAP_PARAMS_SVH

// Stored frame size
`define FRAME_W       16
`define FRAME_H       8
`define FB_DEPTH      (`FRAME_W * `FRAME_H)
`define PIX_BITS      8           // Bits per colour channel

// Line layout in order of active, front porch, sync and back porch
`define H_ACTIVE      16
`define H_FP          2
`define H_SYNC        3
`define H_TOTAL       24

// Frame layout in order of sync, back porch, active and front porch
`define V_SYNC_LINES  2
`define V_BP_LINES    1
`define V_ACTIVE      8
`define V_TOTAL       12

`define STAT_W        8

`endif

//--- verilog/video_pkg.sv
/*
 * Pixel formats, camera word decoding and raster coordinate types
 */
`include "stereo_cap_params.svh"

package video_pkg;

    typedef struct packed {
        logic [`PIX_BITS-1:0] r;
        logic [`PIX_BITS-1:0] g;
        logic [`PIX_BITS-1:0] b;
    } rgb888_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    // One camera pixel seen as the byte pair or as colour
    typedef union packed {
        logic [1:0][7:0] bytes;    // bytes[1] arrives first
        rgb565_t         rgb;
    } cam_word_u;

    typedef logic [$clog2(`H_TOTAL)-1:0] coord_x_t;
    typedef logic [$clog2(`V_TOTAL)-1:0] coord_y_t;

endpackage

//--- verilog/ctrl_pkg.sv
/*
 * Buffer bank, buffer address and capture state types
 */
`include "stereo_cap_params.svh"

package ctrl_pkg;

    typedef logic bank_t;                                  // Which of the two buffers
    typedef logic [$clog2(`FB_DEPTH)-1:0] fb_addr_t;

    typedef enum logic [1:0] {
        CAP_WAIT    = 2'd0,    // Waiting for a camera frame start
        CAP_WRITE   = 2'd1,
        CAP_PENDING = 2'd2,    // Frame complete with the swap not yet done
        CAP_SKIP    = 2'd3     // Current camera frame is dropped
    } cap_state_t;

endpackage

//--- verilog/stereo_cap_ifs.sv
/*
 * fb_mem_if with the frame buffer write and read ports
 * video_timing_if with the address-phase raster position and frame start
 */
`timescale 1ns/10ps

interface fb_mem_if;
    import ctrl_pkg::*;
    import video_pkg::*;

    logic    wr_en;
    bank_t   wr_bank;
    fb_addr_t wr_addr;
    rgb888_t wr_data;
    logic    rd_en;
    bank_t   rd_bank;
    fb_addr_t rd_addr;
    rgb888_t rd_data;    // One cycle after rd_addr

    modport ctrl (output wr_en, wr_bank, wr_addr, wr_data,
                  output rd_en, rd_bank, rd_addr,
                  input  rd_data);
    modport mem  (input  wr_en, wr_bank, wr_addr, wr_data,
                  input  rd_en, rd_bank, rd_addr,
                  output rd_data);
endinterface

interface video_timing_if;
    import video_pkg::*;

    logic     de;
    coord_x_t x;
    coord_y_t y;
    logic     frame_start;    // Both counters at zero

    modport src  (output de, x, y, frame_start);
    modport sink (input  de, x, y, frame_start);
endinterface

//--- verilog/cam_capture.sv
/*
 * Camera byte stream capture
 * Pairs bytes while href is high, expands RGB565 to RGB888
 * and flags the falling edge of vsync as a frame start
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module cam_capture (
    input  logic               clk_50_4m,
    input  logic               rst,
    input  logic               cam_vsync,
    input  logic               cam_href,
    input  logic               cam_byte_valid,
    input  logic [7:0]         cam_data,
    output logic               pix_valid,
    output video_pkg::rgb888_t pix,
    output logic               cam_frame_start
);
    import video_pkg::*;

    cam_word_u word;
    rgb565_t   c565;
    logic      byte_phase;    // Set once the high byte is in
    logic      vsync_q;

    // Control
    always_ff @(posedge clk_50_4m) begin
        if (rst) begin
            byte_phase      <= 1'b0;
            pix_valid       <= 1'b0;
            vsync_q         <= 1'b0;
            cam_frame_start <= 1'b0;
        end else begin
            vsync_q         <= cam_vsync;
            cam_frame_start <= vsync_q & ~cam_vsync;
            pix_valid       <= cam_href & cam_byte_valid & byte_phase;
            if (!cam_href) begin
                byte_phase <= 1'b0;    // Line gap realigns the pair
            end else if (cam_byte_valid) begin
                byte_phase <= ~byte_phase;
            end
        end
    end

    // Byte assembly
    always_ff @(posedge clk_50_4m) begin
        if (cam_href && cam_byte_valid) begin
            if (byte_phase) begin
                word.bytes[0] <= cam_data;
            end else begin
                word.bytes[1] <= cam_data;
            end
        end
    end

    // Each field is topped up with its own MSBs
    assign c565  = word.rgb;
    assign pix.r = {c565.r, c565.r[4 -: `PIX_BITS - 5]};
    assign pix.g = {c565.g, c565.g[5 -: `PIX_BITS - 6]};
    assign pix.b = {c565.b, c565.b[4 -: `PIX_BITS - 5]};

endmodule

//--- verilog/video_timing.sv
/*
 * Raster timing generator
 * Horizontal and vertical counters, address-phase position and enable,
 * and the sync outputs delayed by one cycle to match the buffer read
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module video_timing (
    input  logic clk_50_4m,
    input  logic rst,
    video_timing_if.src vt,
    output logic vid_hs,
    output logic vid_vs,
    output logic vid_de
);
    import video_pkg::*;

    localparam int H_SYNC_START = `H_ACTIVE + `H_FP;
    localparam int V_ACT_START  = `V_SYNC_LINES + `V_BP_LINES;

    coord_x_t h_cnt;
    coord_y_t v_cnt;
    logic     hs;
    logic     vs;
    logic     de;

    // ======================================================================
    // Counters
    // ======================================================================
    always_ff @(posedge clk_50_4m) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == coord_x_t'(`H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == coord_y_t'(`V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign hs = (h_cnt >= coord_x_t'(H_SYNC_START)) &&
                (h_cnt <  coord_x_t'(H_SYNC_START + `H_SYNC));
    assign vs = v_cnt < coord_y_t'(`V_SYNC_LINES);    // Sync lines lead the frame
    assign de = (h_cnt <  coord_x_t'(`H_ACTIVE)) &&
                (v_cnt >= coord_y_t'(V_ACT_START)) &&
                (v_cnt <  coord_y_t'(V_ACT_START + `V_ACTIVE));

    assign vt.de          = de;
    assign vt.x           = h_cnt;
    assign vt.y           = v_cnt - coord_y_t'(V_ACT_START);
    assign vt.frame_start = (h_cnt == '0) && (v_cnt == '0);

    // Output stage one cycle behind the address phase
    always_ff @(posedge clk_50_4m) begin
        if (rst) begin
            vid_hs <= 1'b0;
            vid_vs <= 1'b0;
            vid_de <= 1'b0;
        end else begin
            vid_hs <= hs;
            vid_vs <= vs;
            vid_de <= de;
        end
    end

endmodule

//--- verilog/frame_buf_mem.sv
/*
 * Two-bank frame buffer
 * One write port, one registered read port that returns zero
 * in the cycle after a read was not requested
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module frame_buf_mem (
    input logic clk_50_4m,
    fb_mem_if.mem mem
);
    import ctrl_pkg::*;

    localparam int IDX_W = $bits(bank_t) + $bits(fb_addr_t);

    logic [3*`PIX_BITS-1:0] ram [2*`FB_DEPTH];
    logic [IDX_W-1:0]       wr_idx;
    logic [IDX_W-1:0]       rd_idx;

    // Bank selects the upper half
    assign wr_idx = {mem.wr_bank, mem.wr_addr};
    assign rd_idx = {mem.rd_bank, mem.rd_addr};

    always_ff @(posedge clk_50_4m) begin
        if (mem.wr_en) begin
            ram[wr_idx] <= mem.wr_data;
        end
    end

    // Read register doubles as output blanking
    always_ff @(posedge clk_50_4m) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[rd_idx];
        end else begin
            mem.rd_data <= '0;
        end
    end

endmodule

//--- verilog/img_cap_ctrl.sv
/*
 * Capture control
 * Capture FSM, write address counter, ping-pong bank swap,
 * display read addressing and stored/dropped frame counters
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module img_cap_ctrl (
    input  logic               clk_50_4m,
    input  logic               rst,
    input  logic               pix_valid,
    input  video_pkg::rgb888_t pix,
    input  logic               cam_frame_start,
    video_timing_if.sink       vt,
    fb_mem_if.ctrl             fb,
    output logic [`STAT_W-1:0] frames_stored,
    output logic [`STAT_W-1:0] frames_dropped
);
    import ctrl_pkg::*;

    localparam fb_addr_t LAST_ADDR = fb_addr_t'(`FB_DEPTH - 1);

    cap_state_t state;
    fb_addr_t   wr_addr;
    bank_t      wr_bank;
    bank_t      rd_bank;
    logic       rd_valid;        // A finished frame is on display
    logic       stored_pulse;
    logic       swap;

    // A completed frame waits in wr_bank in both PENDING and SKIP
    assign swap = vt.frame_start && ((state == CAP_PENDING) || (state == CAP_SKIP));

    // ======================================================================
    // Capture FSM
    // ======================================================================
    always_ff @(posedge clk_50_4m) begin
        if (rst) begin
            state          <= CAP_WAIT;
            wr_addr        <= '0;
            wr_bank        <= 1'b0;
            rd_bank        <= 1'b0;
            rd_valid       <= 1'b0;
            stored_pulse   <= 1'b0;
            frames_stored  <= '0;
            frames_dropped <= '0;
        end else begin
            stored_pulse <= 1'b0;
            if (stored_pulse) begin
                frames_stored <= frames_stored + 1'b1;
            end
            case (state)
                CAP_WAIT: begin
                    if (cam_frame_start) begin
                        state   <= CAP_WRITE;
                        wr_addr <= '0;
                    end
                end
                CAP_WRITE: begin
                    if (cam_frame_start) begin
                        wr_addr <= '0;                  // Restart on a new frame
                    end else if (pix_valid) begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == LAST_ADDR) begin
                            state        <= CAP_PENDING;
                            stored_pulse <= 1'b1;
                        end
                    end
                end
                CAP_PENDING, CAP_SKIP: begin
                    if (swap) begin
                        rd_bank  <= wr_bank;
                        rd_valid <= 1'b1;
                        wr_bank  <= ~wr_bank;
                        // A camera frame starting on the swap cycle is kept
                        state    <= cam_frame_start ? CAP_WRITE : CAP_WAIT;
                        wr_addr  <= '0;
                    end else if (cam_frame_start) begin
                        state          <= CAP_SKIP;
                        frames_dropped <= frames_dropped + 1'b1;
                    end
                end
                default: state <= CAP_WAIT;
            endcase
        end
    end

    // Write port
    assign fb.wr_en   = (state == CAP_WRITE) && pix_valid && !cam_frame_start;
    assign fb.wr_bank = wr_bank;
    assign fb.wr_addr = wr_addr;
    assign fb.wr_data = pix;

    // Read port in raster order
    assign fb.rd_en   = vt.de && rd_valid;
    assign fb.rd_bank = rd_bank;
    assign fb.rd_addr = fb_addr_t'(vt.y) * fb_addr_t'(`FRAME_W) + fb_addr_t'(vt.x);

endmodule

//--- verilog/stereo_cap_top.sv
/*
 * Single-camera capture top level
 * Camera capture, raster timing, capture control and frame buffer
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module stereo_cap_top (
    input  logic               clk_50_4m,
    input  logic               rst,
    input  logic               cam_vsync,
    input  logic               cam_href,
    input  logic               cam_byte_valid,
    input  logic [7:0]         cam_data,
    output logic               vid_hs,
    output logic               vid_vs,
    output logic               vid_de,
    output video_pkg::rgb888_t vid_rgb,
    output logic [`STAT_W-1:0] frames_stored,
    output logic [`STAT_W-1:0] frames_dropped
);
    import video_pkg::*;

    logic    pix_valid;
    rgb888_t pix;
    logic    cam_frame_start;

    fb_mem_if       mem_if ();
    video_timing_if vt_if ();

    // ======================================================================
    // Capture side
    // ======================================================================
    cam_capture cam_capture0 (
        .clk_50_4m       (clk_50_4m),
        .rst             (rst),
        .cam_vsync       (cam_vsync),
        .cam_href        (cam_href),
        .cam_byte_valid  (cam_byte_valid),
        .cam_data        (cam_data),
        .pix_valid       (pix_valid),
        .pix             (pix),
        .cam_frame_start (cam_frame_start)
    );

    img_cap_ctrl img_cap_ctrl0 (
        .clk_50_4m       (clk_50_4m),
        .rst             (rst),
        .pix_valid       (pix_valid),
        .pix             (pix),
        .cam_frame_start (cam_frame_start),
        .vt              (vt_if.sink),
        .fb              (mem_if.ctrl),
        .frames_stored   (frames_stored),
        .frames_dropped  (frames_dropped)
    );

    // ======================================================================
    // Display side
    // ======================================================================
    frame_buf_mem frame_buf_mem0 (
        .clk_50_4m (clk_50_4m),
        .mem       (mem_if.mem)
    );

    video_timing video_timing0 (
        .clk_50_4m (clk_50_4m),
        .rst       (rst),
        .vt        (vt_if.src),
        .vid_hs    (vid_hs),
        .vid_vs    (vid_vs),
        .vid_de    (vid_de)
    );

    assign vid_rgb = mem_if.rd_data;    // Already aligned with vid_de

endmodule

//--- tests/stereo_cap_assertions.sv
/*
 * Concurrent checks on the capture controller
 * Bank separation, counter steps and write enable versus state
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module stereo_cap_assertions (
    input logic                 clk_50_4m,
    input logic                 rst,
    input logic                 wr_en,
    input logic                 wr_bank,
    input logic                 rd_bank,
    input logic                 rd_valid,
    input ctrl_pkg::cap_state_t state,
    input logic [`STAT_W-1:0]   frames_stored,
    input logic [`STAT_W-1:0]   frames_dropped
);
    import ctrl_pkg::*;

    // Never write into the bank on display
    bank_sep: assert property (@(posedge clk_50_4m) disable iff (rst)
        (wr_en && rd_valid) |-> (wr_bank != rd_bank))
        else $error("write bank equals the displayed bank");

    stored_step: assert property (@(posedge clk_50_4m) disable iff (rst)
        (frames_stored - $past(frames_stored)) <= `STAT_W'(1))
        else $error("stored counter jumped by more than one");

    dropped_step: assert property (@(posedge clk_50_4m) disable iff (rst)
        (frames_dropped - $past(frames_dropped)) <= `STAT_W'(1))
        else $error("dropped counter jumped by more than one");

    wr_state: assert property (@(posedge clk_50_4m) disable iff (rst)
        wr_en |-> (state == CAP_WRITE))
        else $error("write enable outside the write state");

endmodule

//--- tests/tb_checker.sv
/*
 * Reference model of raster, capture FSM and ping-pong buffers
 * Compares DUT outputs each cycle and prints the per-test results
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module tb_checker (
    input logic                 clk_50_4m,
    input logic                 rst,
    input logic                 cam_vsync,
    input logic                 cam_href,
    input logic                 cam_byte_valid,
    input logic                 vid_hs,
    input logic                 vid_vs,
    input logic                 vid_de,
    input video_pkg::rgb888_t   vid_rgb,
    input logic [`STAT_W-1:0]   frames_stored,
    input logic [`STAT_W-1:0]   frames_dropped
);
    import video_pkg::*;
    import ctrl_pkg::*;

    logic [23:0] mem [2][`FB_DEPTH];
    logic [15:0] pix_q[$];
    int          checks [5];
    int          errors [5];
    int          hc, vc, waddr, stored, dropped, exp_cat;
    logic        exp_hs, exp_vs, exp_de, fs, de;
    logic [23:0] exp_rgb, pv_pix;
    logic        vq, cfs, pv, phase, wbank, rbank, rvalid;
    cap_state_t  st;

    // RGB565 to RGB888 with each field followed by its own top bits
    function automatic logic [23:0] expand(input logic [15:0] p);
        return {p[15:11], p[15:13], p[10:5], p[10:9], p[4:0], p[4:2]};
    endfunction

    task automatic note_pixel(input logic [15:0] p);
        pix_q.push_back(p);
    endtask

    task automatic check(input int t, input logic ok, input string msg);
        checks[t]++;
        if (!ok) begin
            errors[t]++;
            $display("ERROR %0t: %s", $time, msg);
        end
    endtask

    always @(posedge clk_50_4m) begin
        if (rst) begin
            hc      = 0;
            vc      = 0;
            waddr   = 0;
            stored  = 0;
            dropped = 0;
            exp_cat = 0;
            {exp_hs, exp_vs, exp_de, vq, cfs, pv, phase} = '0;
            {wbank, rbank, rvalid} = '0;
            exp_rgb = '0;
            pv_pix  = '0;
            st      = CAP_WAIT;
        end else begin
            // DUT outputs hold what the previous edge produced
            check(0, {vid_hs, vid_vs, vid_de} === {exp_hs, exp_vs, exp_de},
                  $sformatf("sync %b%b%b, expected %b%b%b", vid_hs, vid_vs, vid_de,
                            exp_hs, exp_vs, exp_de));
            check(0, !(vid_hs && vid_de), "vid_de high during hsync");
            check(exp_cat, vid_rgb === exp_rgb,
                  $sformatf("vid_rgb %h, expected %h", vid_rgb, exp_rgb));

            // ============================================================
            // Display side read before this edge's write
            // ============================================================
            fs     = (hc == 0) && (vc == 0);
            de     = (hc < `H_ACTIVE) && (vc >= 3) && (vc < 3 + `V_ACTIVE);
            exp_hs = (hc >= `H_ACTIVE + `H_FP) && (hc < `H_ACTIVE + `H_FP + `H_SYNC);
            exp_vs = vc < `V_SYNC_LINES;
            exp_de = de;
            exp_rgb = (de && rvalid) ? mem[rbank][(vc - 3) * `FRAME_W + hc] : '0;
            // Frames waiting during display count as ping-pong checks
            exp_cat = !rvalid ? 1 : ((st == CAP_PENDING || st == CAP_SKIP) ? 4 : 2);

            // ============================================================
            // Capture FSM
            // ============================================================
            case (st)
                CAP_WAIT: if (cfs) begin
                    st    = CAP_WRITE;
                    waddr = 0;
                end
                CAP_WRITE: begin
                    if (cfs) begin
                        waddr = 0;
                    end else if (pv) begin
                        mem[wbank][waddr] = pv_pix;
                        waddr++;
                        if (waddr == `FB_DEPTH) begin
                            st = CAP_PENDING;
                            stored++;
                        end
                    end
                end
                default: begin
                    if (fs) begin                      // Swap
                        rbank  = wbank;
                        rvalid = 1'b1;
                        wbank  = ~wbank;
                        st     = cfs ? CAP_WRITE : CAP_WAIT;
                        waddr  = 0;
                    end else if (cfs) begin
                        st = CAP_SKIP;
                        dropped++;
                    end
                end
            endcase

            // Camera side as seen by the controller next cycle
            cfs = vq && !cam_vsync;
            vq  = cam_vsync;
            pv  = cam_href && cam_byte_valid && phase;
            if (pv) begin
                if (pix_q.size() == 0) begin
                    check(2, 1'b0, "pixel strobe without a stimulus pixel");
                end else begin
                    pv_pix = expand(pix_q.pop_front());
                end
            end
            phase = cam_href ? (phase ^ cam_byte_valid) : 1'b0;

            hc++;
            if (hc == `H_TOTAL) begin
                hc = 0;
                vc = (vc == `V_TOTAL - 1) ? 0 : vc + 1;
            end
        end
    end

    task automatic report(output int fails);
        string names [5];
        int    total;
        names = '{"raster", "black before data", "colour and storage",
                  "drop rule", "ping-pong integrity"};
        check(3, int'(frames_stored) == stored && int'(frames_dropped) == dropped,
              $sformatf("counters %0d/%0d, expected %0d/%0d", frames_stored,
                        frames_dropped, stored, dropped));
        check(2, pix_q.size() == 0, "stimulus pixels left unconsumed");
        fails = 0;
        total = 0;
        for (int t = 0; t < 5; t++) begin
            $display("Test %0d %s: %0d checks, %0d errors", t + 1, names[t],
                     checks[t], errors[t]);
            fails += errors[t];
            total += checks[t];
        end
        $display("Totals: %0d checks, %0d errors, %0d stored, %0d dropped",
                 total, fails, stored, dropped);
    endtask

endmodule

//--- tests/tb_top.sv
/*
 * Testbench top with clock, reset, seeded camera stimulus,
 * watchdog and the final verdict
 */
`timescale 1ns/10ps
`include "stereo_cap_params.svh"

module tb_top;
    import video_pkg::*;

    localparam int N_FRAMES = 12;

    logic               clk_50_4m;
    logic               rst;
    logic               cam_vsync;
    logic               cam_href;
    logic               cam_byte_valid;
    logic [7:0]         cam_data;
    logic               vid_hs;
    logic               vid_vs;
    logic               vid_de;
    rgb888_t            vid_rgb;
    logic [`STAT_W-1:0] frames_stored;
    logic [`STAT_W-1:0] frames_dropped;
    int                 fails;

    stereo_cap_top dut0 (.*);

    tb_checker chk0 (.*);

    bind img_cap_ctrl stereo_cap_assertions assert0 (
        .clk_50_4m (clk_50_4m), .rst (rst), .wr_en (fb.wr_en),
        .wr_bank (wr_bank), .rd_bank (rd_bank), .rd_valid (rd_valid),
        .state (state), .frames_stored (frames_stored),
        .frames_dropped (frames_dropped)
    );

    initial begin
        clk_50_4m = 1'b0;
        forever #4 clk_50_4m = ~clk_50_4m;
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk_50_4m);
            cam_byte_valid = 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(negedge clk_50_4m);
        cam_byte_valid = 1'b1;
        cam_data       = b;
        if ($urandom % 8 == 0) idle(1);    // Occasional strobe gap
    endtask

    task automatic send_frame();
        logic [15:0] p;
        @(negedge clk_50_4m);
        cam_vsync = 1'b1;
        idle(3);
        cam_vsync = 1'b0;
        idle(2);
        for (int l = 0; l < `FRAME_H; l++) begin
            cam_href = 1'b1;
            for (int i = 0; i < `FRAME_W; i++) begin
                p = 16'($urandom);
                send_byte(p[15:8]);
                chk0.note_pixel(p);
                send_byte(p[7:0]);
            end
            idle(1);
            cam_href = 1'b0;
            idle(2);
        end
    endtask

    // ======================================================================
    // Watchdog over 20 display frames
    // ======================================================================
    initial begin
        #(20 * `H_TOTAL * `V_TOTAL * 8);
        $display("Timeout: camera frames were not all stored or dropped in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h0ed520d2));
        rst            = 1'b1;
        cam_vsync      = 1'b0;
        cam_href       = 1'b0;
        cam_byte_valid = 1'b0;
        cam_data       = 8'h00;
        repeat (2) @(negedge clk_50_4m);
        rst = 1'b0;
        idle(5);
        for (int f = 0; f < N_FRAMES; f++) begin
            send_frame();
            // Tight spacing forces drops while a frame waits
            idle((f % 4 == 1 || f % 4 == 2) ? 2 : 20 + $urandom % 100);
        end
        wait (int'(frames_stored) + int'(frames_dropped) == N_FRAMES);
        repeat (2) @(posedge vid_vs);    // Last stored frame on display
        repeat (4) @(negedge clk_50_4m);
        chk0.report(fails);
        if (fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/video_pkg.sv
verilog/ctrl_pkg.sv
verilog/stereo_cap_ifs.sv
verilog/cam_capture.sv
verilog/video_timing.sv
verilog/frame_buf_mem.sv
verilog/img_cap_ctrl.sv
verilog/stereo_cap_top.sv
tests/stereo_cap_assertions.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the capture path testbench with Verilator

rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_top -f sources.f \
    -o tb_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log

grep -q "Something failed" sim.log && exit 1
grep -q "Simulator returned an error status" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0
